/* fft16.f */
source/fft16_pkg.sv
source/sample_collector.sv
source/butterfly_stage.sv
source/fft16_top.sv
verification/fft16_asserts.sv
verification/fft16_tb.sv

/* Bender.yml */
package:
  name: fft16

sources:
  # Package first, then the RTL from the leaves up to the top level
  - files:
      - source/fft16_pkg.sv
      - source/sample_collector.sv
      - source/butterfly_stage.sv
      - source/fft16_top.sv

  # Testbench and the bound port assertions
  - target: test
    files:
      - verification/fft16_asserts.sv
      - verification/fft16_tb.sv

/* verification/fft16_tb.sv */
`timescale 1ns/1ps

module fft16_tb;

  import fft16_pkg::*;

  localparam int N_PATTERNS = 4;
  localparam int LATENCY    = 5;            // Cycles from the 16th sample to fft_valid
  localparam int VALID_WAIT = 20;           // Cycles allowed for a spectrum to appear
  localparam int FRAME_WAIT = 100;          // Cycles allowed for the driver to finish a frame

  logic      clk;
  logic      arst_n;
  sample_t   fir_d;
  logic      fir_valid;
  spectrum_t fft_d;
  logic      fft_valid;

  string   pat_name [N_PATTERNS];
  sample_t pat_x    [N_PATTERNS][N_POINTS];
  bin_t    pat_want [N_PATTERNS][N_POINTS];  // Expected bins in natural order

  int          cycle;                       // Rising edges seen so far
  int          take_q[$];                   // Cycle in which each frame's 16th sample is driven
  int          pat_q[$];                    // Table entry of each frame in flight
  logic [31:0] lcg_state;

  fft16_top u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .fir_d     (fir_d),
    .fir_valid (fir_valid),
    .fft_d     (fft_d),
    .fft_valid (fft_valid)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_on_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // Watches the failure count of the bound port assertions
  always @(negedge clk) begin
    assert (u_dut.u_asserts.fail_count == 0) else begin
      $display("Concurrent assertions on the DUT ports failed at %0t", $time);
      stop_on_failure();
    end
  end

  // Expected bins follow X[k] = sum x[n] * exp(-j*2*pi*k*n/16) and are exact in Q8.8
  task automatic build_table();
    for (int p = 0; p < N_PATTERNS; p++) begin
      for (int n = 0; n < N_POINTS; n++) begin
        pat_x[p][n]    = '0;
        pat_want[p][n] = '0;
      end
    end
    pat_name[0] = "impulse";
    pat_x[0][0] = 16'sh0200;                // 2.0
    for (int k = 0; k < N_POINTS; k++) begin
      pat_want[0][k] = '{re: 16'sh0200, im: 16'sh0000};
    end
    pat_name[1] = "constant";
    for (int n = 0; n < N_POINTS; n++) begin
      pat_x[1][n] = 16'sh0080;              // 0.5
    end
    pat_want[1][0].re = 16'sh0800;          // 8.0
    pat_name[2] = "alternating";
    for (int n = 0; n < N_POINTS; n++) begin
      pat_x[2][n] = (n % 2 == 0) ? 16'sh0040 : 16'shFFC0;  // +0.25 and -0.25
    end
    pat_want[2][8].re = 16'sh0400;          // 4.0
    pat_name[3] = "cosine";
    for (int n = 0; n < N_POINTS; n++) begin
      case (n % 4)
        0:       pat_x[3][n] = 16'sh0080;
        2:       pat_x[3][n] = 16'shFF80;
        default: pat_x[3][n] = 16'sh0000;
      endcase
    end
    pat_want[3][4].re  = 16'sh0400;
    pat_want[3][12].re = 16'sh0400;         // Mirror bin of the real tone
  endtask

  task automatic send_sample(input sample_t x);
    @(posedge clk);
    #1;
    fir_d     = x;
    fir_valid = 1'b1;
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    #1;
    fir_d     = '0;
    fir_valid = 1'b0;
  endtask

  // Streams every table entry, with random idle cycles when gaps is set
  task automatic stream_patterns(input bit gaps);
    for (int p = 0; p < N_PATTERNS; p++) begin
      for (int n = 0; n < N_POINTS; n++) begin
        if (gaps) begin
          lcg_state = next_random(lcg_state);
          if (lcg_state[31]) begin
            idle_cycle();
          end
        end
        send_sample(pat_x[p][n]);
      end
      take_q.push_back(cycle);
      pat_q.push_back(p);
    end
    idle_cycle();
  endtask

  task automatic check_frames(input int n_frames);
    int take_cyc;
    int p;
    int waited;
    for (int f = 0; f < n_frames; f++) begin
      waited = 0;
      while (take_q.size() == 0) begin
        @(negedge clk);
        waited++;
        assert (!fft_valid) else begin
          $display("ERROR at %0t: fft_valid expected 0, got 1 with no frame pending", $time);
          stop_on_failure();
        end
        if (waited > FRAME_WAIT) begin
          $display("Timeout: the driver completed no frame within %0d cycles", FRAME_WAIT);
          stop_on_failure();
        end
      end
      take_cyc = take_q.pop_front();
      p        = pat_q.pop_front();
      waited   = 0;
      do begin
        @(negedge clk);
        waited++;
        if (waited > VALID_WAIT) begin
          $display("Timeout: fft_valid did not rise for frame %0d (%s) within %0d cycles",
                   f, pat_name[p], VALID_WAIT);
          stop_on_failure();
        end
      end while (!fft_valid);
      assert (cycle - take_cyc == LATENCY) else begin
        $display("ERROR at %0t: fft_valid latency expected %0d, got %0d (%s)",
                 $time, LATENCY, cycle - take_cyc, pat_name[p]);
        stop_on_failure();
      end
      for (int k = 0; k < N_POINTS; k++) begin
        assert (fft_d[k] == pat_want[p][k]) else begin
          $display("ERROR at %0t: fft_d[%0d] expected (%0d, %0d), got (%0d, %0d) (%s)",
                   $time, k, pat_want[p][k].re, pat_want[p][k].im,
                   fft_d[k].re, fft_d[k].im, pat_name[p]);
          stop_on_failure();
        end
      end
      $display("Frame %0d (%s) matched at %0t", f, pat_name[p], $time);
    end
  endtask

  initial begin
    int assert_fails;
    clk       = 1'b0;
    arst_n    = 1'b0;
    fir_d     = '0;
    fir_valid = 1'b0;
    cycle     = 0;
    lcg_state = 32'h4235_e300;
    build_table();
    repeat (3) begin
      @(posedge clk);
      #1;
      assert (!fft_valid) else begin
        $display("ERROR at %0t: fft_valid expected 0, got 1 during reset", $time);
        stop_on_failure();
      end
    end
    arst_n = 1'b1;
    fork
      begin
        stream_patterns(1'b0);              // Back to back so frames overlap in the stages
        stream_patterns(1'b1);
      end
      check_frames(2 * N_PATTERNS);
    join
    repeat (3) @(negedge clk);              // Let the last concurrent checks fire
    assert_fails = u_dut.u_asserts.fail_count;
    if (assert_fails == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("Concurrent assertions on the DUT ports failed %0d times", assert_fails);
      stop_on_failure();
    end
  end

endmodule

/* verification/fft16_asserts.sv */
`timescale 1ns/1ps

module fft16_asserts (
  input logic               clk,
  input logic               arst_n,
  input fft16_pkg::sample_t fir_d,
  input logic               fir_valid,
  input logic               fft_valid
);

  localparam int LATENCY = 5;               // Collector plus four stages

  int fail_count = 0;                       // Failures of the properties below

  single_pulse: assert property (@(posedge clk) disable iff (!arst_n)
    fft_valid |=> !fft_valid)
    else begin
      $error("fft_valid stayed high for two cycles");
      fail_count++;
    end

  // Every spectrum must come from a sample taken LATENCY cycles before
  valid_latency: assert property (@(posedge clk) disable iff (!arst_n)
    fft_valid |-> $past(fir_valid, LATENCY))
    else begin
      $error("fft_valid without a sample %0d cycles earlier", LATENCY);
      fail_count++;
    end

  known_sample: assert property (@(posedge clk) disable iff (!arst_n)
    fir_valid |-> !$isunknown(fir_d))
    else begin
      $error("fir_d has unknown bits while fir_valid is high");
      fail_count++;
    end

endmodule

bind fft16_top fft16_asserts u_asserts (
  .clk       (clk),
  .arst_n    (arst_n),
  .fir_d     (fir_d),
  .fir_valid (fir_valid),
  .fft_valid (fft_valid)
);

/* source/fft16_top.sv */
`timescale 1ns/1ps

module fft16_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  fft16_pkg::sample_t    fir_d,
  input  logic                  fir_valid,
  output fft16_pkg::spectrum_t  fft_d,
  output logic                  fft_valid
);

  import fft16_pkg::*;

  localparam int LSB = FRAC_W - SAMPLE_W / 2;  // Q16.16 bit that becomes the Q8.8 LSB

  frame_t frame_c;                          // Collected input frame
  frame_t frame_s8;
  frame_t frame_s4;
  frame_t frame_s2;
  frame_t frame_s1;                         // Bins in bit-reversed order
  logic   valid_c;
  logic   valid_s8;
  logic   valid_s4;
  logic   valid_s2;

  sample_collector u_collector (
    .clk         (clk),
    .arst_n      (arst_n),
    .fir_d       (fir_d),
    .fir_valid   (fir_valid),
    .frame       (frame_c),
    .frame_valid (valid_c)
  );

  butterfly_stage #(.SPAN(8)) u_stage8 (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_frame  (frame_c),
    .in_valid  (valid_c),
    .out_frame (frame_s8),
    .out_valid (valid_s8)
  );

  butterfly_stage #(.SPAN(4)) u_stage4 (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_frame  (frame_s8),
    .in_valid  (valid_s8),
    .out_frame (frame_s4),
    .out_valid (valid_s4)
  );

  butterfly_stage #(.SPAN(2)) u_stage2 (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_frame  (frame_s4),
    .in_valid  (valid_s4),
    .out_frame (frame_s2),
    .out_valid (valid_s2)
  );

  butterfly_stage #(.SPAN(1)) u_stage1 (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_frame  (frame_s2),
    .in_valid  (valid_s2),
    .out_frame (frame_s1),
    .out_valid (fft_valid)
  );

  // Natural order output, truncated from Q16.16 to Q8.8
  for (genvar k = 0; k < N_POINTS; k++) begin : g_bin
    localparam int SRC = bit_reverse(IDX_W'(k));
    assign fft_d[k].re = frame_s1[SRC].re[LSB +: SAMPLE_W];
    assign fft_d[k].im = frame_s1[SRC].im[LSB +: SAMPLE_W];
  end

endmodule

/* source/butterfly_stage.sv */
`timescale 1ns/1ps

module butterfly_stage #(
  parameter int SPAN = 8
) (
  input  logic              clk,
  input  logic              arst_n,
  input  fft16_pkg::frame_t in_frame,
  input  logic              in_valid,
  output fft16_pkg::frame_t out_frame,
  output logic              out_valid
);

  import fft16_pkg::*;

  localparam int STRIDE = (N_POINTS / 2) / SPAN;  // Twiddle index step within a group

  frame_t result;                           // Combinational stage output

  // Complex product with each partial product truncated back to Q16.16
  function automatic cplx_t cmul(input cplx_t a, input cplx_t w);
    logic signed [2*ACC_W-1:0] rr;
    logic signed [2*ACC_W-1:0] ii;
    logic signed [2*ACC_W-1:0] ri;
    logic signed [2*ACC_W-1:0] ir;
    cplx_t                     p;
    rr   = a.re * w.re;
    ii   = a.im * w.im;
    ri   = a.re * w.im;
    ir   = a.im * w.re;
    p.re = ACC_W'(rr >>> FRAC_W) - ACC_W'(ii >>> FRAC_W);
    p.im = ACC_W'(ri >>> FRAC_W) + ACC_W'(ir >>> FRAC_W);
    return p;
  endfunction

  // Each of the N_POINTS/2 butterflies pairs point top with point top+SPAN
  always_comb begin
    int    grp;
    int    ofs;
    int    top;
    int    bot;
    cplx_t a;
    cplx_t b;
    cplx_t diff;
    for (int p = 0; p < N_POINTS / 2; p++) begin
      grp = p / SPAN;                       // Group of 2*SPAN points
      ofs = p % SPAN;                       // Position inside the upper half
      top = grp * 2 * SPAN + ofs;
      bot = top + SPAN;
      a   = in_frame[top];
      b   = in_frame[bot];

      result[top].re = a.re + b.re;         // Sums wrap without scaling
      result[top].im = a.im + b.im;

      diff.re     = a.re - b.re;
      diff.im     = a.im - b.im;
      result[bot] = cmul(diff, TWIDDLE[ofs * STRIDE]);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;                // Exactly one cycle through the stage
    end
  end

  // Frame holds between valids so the last stage keeps its spectrum stable
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_frame <= result;
    end
  end

endmodule

/* source/sample_collector.sv */
`timescale 1ns/1ps

module sample_collector (
  input  logic               clk,
  input  logic               arst_n,
  input  fft16_pkg::sample_t fir_d,
  input  logic               fir_valid,
  output fft16_pkg::frame_t  frame,
  output logic               frame_valid
);

  import fft16_pkg::*;

  localparam int SHIFT = FRAC_W - SAMPLE_W / 2;  // Q8.8 to Q16.16 alignment

  logic [IDX_W-1:0] count;                  // Position of the next sample in the frame
  logic             last;                   // Current sample completes the frame
  cplx_t            sample_c;               // Incoming sample in the internal format
  frame_t           staging;
  frame_t           frame_next;

  always_comb begin
    sample_c.re = ACC_W'(fir_d) <<< SHIFT;  // Sign extend, then move the binary point
    sample_c.im = '0;
  end

  assign last = (count == IDX_W'(N_POINTS - 1));

  // The 16th sample goes straight to the output without waiting in the buffer
  always_comb begin
    frame_next        = staging;
    frame_next[count] = sample_c;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count       <= '0;
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= fir_valid && last;     // One cycle pulse per frame
      if (fir_valid) begin
        count <= count + 1'b1;              // Wraps to 0 after the last sample
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fir_valid) begin
      staging[count] <= sample_c;
    end
    if (fir_valid && last) begin
      frame <= frame_next;
    end
  end

endmodule

/* source/fft16_pkg.sv */
package fft16_pkg;

  localparam int N_POINTS = 16;             // Transform size
  localparam int IDX_W    = $clog2(N_POINTS);  // Width of a point index
  localparam int SAMPLE_W = 16;             // Q8.8 input sample and bin component
  localparam int ACC_W    = 32;             // Q16.16 internal component
  localparam int FRAC_W   = 16;             // Fractional bits of the internal format

  // Serial input word, signed Q8.8
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  typedef struct packed {
    logic signed [ACC_W-1:0] re;            // Real part, Q16.16
    logic signed [ACC_W-1:0] im;            // Imaginary part, Q16.16
  } cplx_t;

  // One complete frame of points travelling between stages
  typedef cplx_t [N_POINTS-1:0] frame_t;

  typedef struct packed {
    logic signed [SAMPLE_W-1:0] re;         // Real part, Q8.8
    logic signed [SAMPLE_W-1:0] im;         // Imaginary part, Q8.8
  } bin_t;

  // Output spectrum indexed by frequency bin
  typedef bin_t [N_POINTS-1:0] spectrum_t;

  // W16^k = cos(2*pi*k/16) - j*sin(2*pi*k/16) in Q16.16 for k = 0..7
  localparam cplx_t [0:N_POINTS/2-1] TWIDDLE = '{
    '{re: 32'sh0001_0000, im: 32'sh0000_0000},   // 1.0
    '{re: 32'sh0000_EC83, im: 32'shFFFF_9E09},   // 0.9239, -0.3827
    '{re: 32'sh0000_B504, im: 32'shFFFF_4AFC},   // 0.7071, -0.7071
    '{re: 32'sh0000_61F7, im: 32'shFFFF_137D},   // 0.3827, -0.9239
    '{re: 32'sh0000_0000, im: 32'shFFFF_0000},   // -j
    '{re: 32'shFFFF_9E09, im: 32'shFFFF_137D},   // -0.3827, -0.9239
    '{re: 32'shFFFF_4AFC, im: 32'shFFFF_4AFC},   // -0.7071, -0.7071
    '{re: 32'shFFFF_137D, im: 32'shFFFF_9E09}    // -0.9239, -0.3827
  };

  // Decimation in frequency leaves the bins in bit-reversed order,
  // so the output mapping needs the mirrored index
  function automatic logic [IDX_W-1:0] bit_reverse(input logic [IDX_W-1:0] idx);
    logic [IDX_W-1:0] rev;
    for (int b = 0; b < IDX_W; b++) begin
      rev[b] = idx[IDX_W-1-b];              // Swap bit b with its mirror
    end
    return rev;
  endfunction

endpackage
